// ==== hdl/arcade_ctrl_pkg.sv ====
/* Control-side types shared by the host registers, key latch and control mapper.
   Joystick bits 6 and 7 are carried but never used by the game. */

`default_nettype none

package arcade_ctrl_pkg;

	// --------------------
	// Keyboard
	typedef struct packed {
		logic       valid;   // One-cycle strobe
		logic       pressed; // 1 make, 0 break
		logic [7:0] code;    // Scan code
	} key_event_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic start1;
		logic start2;
	} key_buttons_t;

	// --------------------
	// Joystick and game buttons
	typedef struct packed {
		logic [1:0] unused;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right; // Bit 0
	} joy_t;

	// All active low
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic left;
		logic right;
		logic up;
		logic down;
	} game_buttons_t;

	// --------------------
	// Status word and register map
	localparam int STATUS_RESET       = 0;
	localparam int STATUS_ROTATE      = 2; // 1 is normal orientation
	localparam int STATUS_SCAN_LO     = 3;
	localparam int STATUS_SCAN_HI     = 4;
	localparam int STATUS_BLEND       = 5;
	localparam int STATUS_RESET_PULSE = 6;

	localparam logic [1:0] ADDR_STATUS = 2'd0;
	localparam logic [1:0] ADDR_JOY    = 2'd1; // Joy 1 in 15:8, joy 0 in 7:0
	localparam logic [1:0] ADDR_KEY    = 2'd2; // Pressed in 8, code in 7:0

endpackage

`default_nettype wire

// ==== hdl/arcade_av_pkg.sv ====
/* Video types on both sides of the blanking gate.
   Colour depth is fixed at 2 bits per channel. */

`default_nettype none

package arcade_av_pkg;

	// --------------------
	// Video from the game core
	typedef struct packed {
		logic [1:0] r;
		logic [1:0] g;
		logic [1:0] b;
		logic       hs;        // Active high from the core
		logic       vs;
		logic       vblank;
		logic       hblank_bg; // Background layer blank
		logic       hblank_fg; // Foreground layer blank
	} core_video_t;

	// --------------------
	// Video toward the board DAC pins
	typedef struct packed {
		logic [1:0] r;
		logic [1:0] g;
		logic [1:0] b;
		logic       hs; // Inverted
		logic       vs; // Inverted
	} board_video_t;

endpackage

`default_nettype wire

// ==== hdl/host_status_regs.sv ====
/* Wishbone classic slave, no wait states; ack is registered and lasts one cycle.
   Reads of the key address return zero, key writes become a one-cycle event. */

`timescale 1ns/1ps
`default_nettype none

module host_status_regs (
	input  logic                        clk_28,
	input  logic                        reset,
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  logic [1:0]                  wb_adr,
	input  logic [31:0]                 wb_dat_w,
	output logic [31:0]                 wb_dat_r,
	output logic                        wb_ack,
	output logic [31:0]                 status,
	output arcade_ctrl_pkg::joy_t       joy_0,
	output arcade_ctrl_pkg::joy_t       joy_1,
	output arcade_ctrl_pkg::key_event_t key_event
);

	logic       req;       // New request this cycle
	logic       key_pend;  // Key write acked, event goes out next cycle
	logic       key_valid;
	logic       key_pressed_q;
	logic [7:0] key_code_q;

	assign req = wb_cyc & wb_stb & ~wb_ack;

	// --------------------
	// Ack and control registers
	always_ff @(posedge clk_28) begin
		if (reset) begin
			wb_ack    <= 1'b0;
			status    <= '0;
			joy_0     <= '0;
			joy_1     <= '0;
			key_pend  <= 1'b0;
			key_valid <= 1'b0;
		end else begin
			wb_ack    <= req;
			key_valid <= key_pend;
			key_pend  <= 1'b0;
			if (req && wb_we) begin
				case (wb_adr)
					arcade_ctrl_pkg::ADDR_STATUS: status <= wb_dat_w;
					arcade_ctrl_pkg::ADDR_JOY: begin
						joy_0 <= arcade_ctrl_pkg::joy_t'(wb_dat_w[7:0]);
						joy_1 <= arcade_ctrl_pkg::joy_t'(wb_dat_w[15:8]);
					end
					arcade_ctrl_pkg::ADDR_KEY: key_pend <= 1'b1;
					default: ; // Address 3 unmapped
				endcase
			end
		end
	end

	// --------------------
	// Read data and key payload
	always_ff @(posedge clk_28) begin
		if (req) begin
			case (wb_adr)
				arcade_ctrl_pkg::ADDR_STATUS: wb_dat_r <= status;
				arcade_ctrl_pkg::ADDR_JOY:    wb_dat_r <= {16'h0000, joy_1, joy_0};
				default:                      wb_dat_r <= '0;
			endcase
		end
		if (req && wb_we && wb_adr == arcade_ctrl_pkg::ADDR_KEY) begin
			key_pressed_q <= wb_dat_w[8];
			key_code_q    <= wb_dat_w[7:0];
		end
	end

	assign key_event = '{valid: key_valid, pressed: key_pressed_q, code: key_code_q};

	// --------------------
	// Bus protocol checks
	ack_single_cycle: assert property (
		@(posedge clk_28) disable iff (reset)
		wb_ack |=> !wb_ack
	);

	// An ack without a request the cycle before would confuse a classic master
	ack_after_request: assert property (
		@(posedge clk_28) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb)
	);

endmodule

`default_nettype wire

// ==== hdl/ps2_key_latch.sv ====
/* Holds one latch per known scan code; extended (E0) prefixes are not decoded,
   so the arrow keys share codes with the keypad. */

`timescale 1ns/1ps
`default_nettype none

module ps2_key_latch (
	input  logic                          clk_28,
	input  logic                          reset,
	input  arcade_ctrl_pkg::key_event_t   key_event,
	output arcade_ctrl_pkg::key_buttons_t keys
);

	// --------------------
	// Scan codes, set 2
	localparam logic [7:0] CODE_UP     = 8'h75;
	localparam logic [7:0] CODE_DOWN   = 8'h72;
	localparam logic [7:0] CODE_LEFT   = 8'h6B;
	localparam logic [7:0] CODE_RIGHT  = 8'h74;
	localparam logic [7:0] CODE_COIN   = 8'h76; // Esc
	localparam logic [7:0] CODE_START1 = 8'h05; // F1
	localparam logic [7:0] CODE_START2 = 8'h06; // F2
	localparam logic [7:0] CODE_FIRE1  = 8'h29; // Space
	localparam logic [7:0] CODE_FIRE2  = 8'h11; // Alt

	always_ff @(posedge clk_28) begin
		if (reset) begin
			keys <= '0;
		end else if (key_event.valid) begin
			case (key_event.code)
				CODE_UP:     keys.up     <= key_event.pressed;
				CODE_DOWN:   keys.down   <= key_event.pressed;
				CODE_LEFT:   keys.left   <= key_event.pressed;
				CODE_RIGHT:  keys.right  <= key_event.pressed;
				CODE_COIN:   keys.coin   <= key_event.pressed;
				CODE_START1: keys.start1 <= key_event.pressed;
				CODE_START2: keys.start2 <= key_event.pressed;
				CODE_FIRE1:  keys.fire1  <= key_event.pressed;
				CODE_FIRE2:  keys.fire2  <= key_event.pressed;
				default: ; // Unknown key, latches hold
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/control_mapper.sv ====
/* The game core has one start input pair tied to coin, so the start keys are
   latched but do not reach it. Rotate bit low turns the controls 90 degrees. */

`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  logic                           clk_28,
	input  logic                           reset,
	input  arcade_ctrl_pkg::key_buttons_t  keys,
	input  arcade_ctrl_pkg::joy_t          joy_0,
	input  arcade_ctrl_pkg::joy_t          joy_1,
	input  logic [31:0]                    status,
	output arcade_ctrl_pkg::game_buttons_t buttons,
	output logic                           core_reset
);

	arcade_ctrl_pkg::joy_t joy_any; // Either stick
	logic                  normal;
	logic                  m_up;
	logic                  m_down;
	logic                  m_left;
	logic                  m_right;
	logic                  m_fire;

	assign joy_any = arcade_ctrl_pkg::joy_t'(joy_0 | joy_1);
	assign normal  = status[arcade_ctrl_pkg::STATUS_ROTATE];

	// --------------------
	// Direction merge
	assign m_up    = normal ? (keys.up | joy_any.up) : (keys.left | joy_any.left);
	assign m_down  = normal ? (keys.down | joy_any.down) : (keys.right | joy_any.right);
	assign m_left  = normal ? (keys.left | joy_any.left) : (keys.down | joy_any.down);
	assign m_right = normal ? (keys.right | joy_any.right) : (keys.up | joy_any.up);
	assign m_fire  = keys.fire1 | joy_any.fire1;

	always_ff @(posedge clk_28) begin
		if (reset) begin
			buttons    <= '1; // Nothing pressed
			core_reset <= 1'b1;
		end else begin
			buttons.coin   <= ~keys.coin;
			buttons.start1 <= ~keys.coin; // Core starts on coin
			buttons.start2 <= ~keys.coin;
			buttons.fire   <= ~m_fire;
			buttons.left   <= ~m_left;
			buttons.right  <= ~m_right;
			buttons.up     <= ~m_up;
			buttons.down   <= ~m_down;
			core_reset     <= status[arcade_ctrl_pkg::STATUS_RESET] |
				status[arcade_ctrl_pkg::STATUS_RESET_PULSE];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/video_blank_gate.sv ====
/* One register stage; the caller must delay anything aligned to video by a cycle.
   Colour is gated only when both horizontal blanks are active. */

`timescale 1ns/1ps
`default_nettype none

module video_blank_gate (
	input  logic                        clk_28,
	input  logic                        reset,
	input  arcade_av_pkg::core_video_t  core_video,
	output arcade_av_pkg::board_video_t board_video
);

	logic blank;

	// Both layers must be in hblank before the line goes dark
	assign blank = (core_video.hblank_bg & core_video.hblank_fg) | core_video.vblank;

	always_ff @(posedge clk_28) begin
		if (reset) begin
			board_video <= '0;
		end else begin
			board_video.r  <= blank ? 2'b00 : core_video.r;
			board_video.g  <= blank ? 2'b00 : core_video.g;
			board_video.b  <= blank ? 2'b00 : core_video.b;
			board_video.hs <= ~core_video.hs; // Board wants active low
			board_video.vs <= ~core_video.vs;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sigma_delta_dac.sv ====
/* First-order only, so idle tones appear at low sample values.
   DAC_BITS must be 8 or 16; the sample is replicated to fill the accumulator. */

`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic       clk_28,
	input  logic       reset,
	input  logic [7:0] sample,
	output logic       audio_l,
	output logic       audio_r
);

	logic [DAC_BITS-1:0] sample_wide; // Full-scale copy of the sample
	logic [DAC_BITS-1:0] acc;
	logic [DAC_BITS:0]   sum;
	logic                bit_q;

	assign sample_wide = {(DAC_BITS / 8){sample}};
	assign sum         = {1'b0, acc} + {1'b0, sample_wide};

	always_ff @(posedge clk_28) begin
		if (reset) begin
			acc   <= '0;
			bit_q <= 1'b0;
		end else begin
			acc   <= sum[DAC_BITS-1:0];
			bit_q <= sum[DAC_BITS]; // Carry is the bitstream
		end
	end

	// Mono core, same stream on both channels
	assign audio_l = bit_q;
	assign audio_r = bit_q;

	dac_bits_legal: assert property (
		@(posedge clk_28) (DAC_BITS == 8) || (DAC_BITS == 16)
	);

endmodule

`default_nettype wire

// ==== hdl/arcade_io_top.sv ====
/* Board-side glue around the game core; the core and PLL live outside.
   All logic runs on clk_28 with a synchronous active-high reset. */

`timescale 1ns/1ps
`default_nettype none

module arcade_io_top #(
	parameter int DAC_BITS = 16
) (
	input  logic                           clk_28,
	input  logic                           reset,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [1:0]                     wb_adr,
	input  logic [31:0]                    wb_dat_w,
	output logic [31:0]                    wb_dat_r,
	output logic                           wb_ack,
	input  arcade_av_pkg::core_video_t     core_video,
	input  logic [7:0]                     audio_sample,
	output arcade_ctrl_pkg::game_buttons_t buttons,
	output logic                           core_reset,
	output arcade_av_pkg::board_video_t    board_video,
	output logic                           audio_l,
	output logic                           audio_r
);

	logic [31:0]                   status;
	arcade_ctrl_pkg::joy_t         joy_0;
	arcade_ctrl_pkg::joy_t         joy_1;
	arcade_ctrl_pkg::key_event_t   key_event;
	arcade_ctrl_pkg::key_buttons_t keys;

	// --------------------
	// Control path
	host_status_regs regs_i (
		.clk_28, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .status, .joy_0, .joy_1, .key_event
	);

	ps2_key_latch keys_i (.clk_28, .reset, .key_event, .keys);

	control_mapper mapper_i (
		.clk_28, .reset, .keys, .joy_0, .joy_1, .status, .buttons, .core_reset
	);

	// --------------------
	// Audio and video
	video_blank_gate video_i (.clk_28, .reset, .core_video, .board_video);

	sigma_delta_dac #(.DAC_BITS(DAC_BITS)) dac_i (
		.clk_28, .reset, .sample(audio_sample), .audio_l, .audio_r
	);

endmodule

`default_nettype wire

// ==== verification/arcade_io_tb_model.svh ====
/* Reference model and Wishbone master tasks, included inside the testbench module.
   Bus tasks must be called 2 ns after a rising edge. */

`ifndef ARCADE_IO_TB_MODEL_SVH
`define ARCADE_IO_TB_MODEL_SVH

	// --------------------
	// Value check and bus tasks
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic wait_for_ack();
		int waited;
		waited = 0;
		do begin
			@(posedge clk_28);
			#DRIVE_DELAY;
			waited++;
		end while (!wb_ack && waited < ACK_TIMEOUT);
		if (!wb_ack) begin
			$display("Wishbone slave gave no ack within %0d cycles", ACK_TIMEOUT);
			$display("SIMULATION FAILED");
			$fatal(1, "Bus timeout");
		end
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		wait_for_ack();
		wb_cyc = 1'b0; // Drop the request in the ack cycle
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_for_ack();
		data   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// --------------------
	// Model functions
	function automatic arcade_ctrl_pkg::key_buttons_t latch_key(
		arcade_ctrl_pkg::key_buttons_t k, logic pressed, logic [7:0] code);
		latch_key = k;
		case (code)
			8'h75: latch_key.up     = pressed;
			8'h72: latch_key.down   = pressed;
			8'h6B: latch_key.left   = pressed;
			8'h74: latch_key.right  = pressed;
			8'h76: latch_key.coin   = pressed;
			8'h05: latch_key.start1 = pressed;
			8'h06: latch_key.start2 = pressed;
			8'h29: latch_key.fire1  = pressed;
			8'h11: latch_key.fire2  = pressed;
			default: ;
		endcase
	endfunction

	function automatic arcade_ctrl_pkg::game_buttons_t map_buttons(
		arcade_ctrl_pkg::key_buttons_t k, logic [7:0] j0, logic [7:0] j1, logic normal);
		logic [7:0] j;
		logic       u, d, l, r;
		j = j0 | j1;
		u = k.up | j[3];
		d = k.down | j[2];
		l = k.left | j[1];
		r = k.right | j[0];
		map_buttons.coin   = ~k.coin;
		map_buttons.start1 = ~k.coin;
		map_buttons.start2 = ~k.coin;
		map_buttons.fire   = ~(k.fire1 | j[4]);
		map_buttons.up     = ~(normal ? u : l); // Rotated: left becomes up
		map_buttons.down   = ~(normal ? d : r);
		map_buttons.left   = ~(normal ? l : d);
		map_buttons.right  = ~(normal ? r : u);
	endfunction

	function automatic arcade_av_pkg::board_video_t gate_video(arcade_av_pkg::core_video_t v);
		logic dark;
		dark = v.vblank | (v.hblank_bg & v.hblank_fg);
		gate_video.r  = dark ? 2'b00 : v.r;
		gate_video.g  = dark ? 2'b00 : v.g;
		gate_video.b  = dark ? 2'b00 : v.b;
		gate_video.hs = ~v.hs;
		gate_video.vs = ~v.vs;
	endfunction

`endif

// ==== verification/arcade_io_tb.sv ====
/* Self-checking testbench for arcade_io_top with an 8-bit DAC.
   Stimulus is random from a fixed seed; inputs change 2 ns after each rising edge. */

`timescale 1ns/1ps
`default_nettype none

module arcade_io_tb;

	localparam int CLK_HALF    = 20; // 40 ns period
	localparam int DRIVE_DELAY = 2;
	localparam int ACK_TIMEOUT = 16;
	localparam int MAX_CYCLES  = 20000;
	localparam logic [7:0] KNOWN_CODES [9] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h76,
		8'h05, 8'h06, 8'h29, 8'h11};

	logic                           clk_28;
	logic                           reset;
	logic                           wb_cyc, wb_stb, wb_we, wb_ack;
	logic [1:0]                     wb_adr;
	logic [31:0]                    wb_dat_w, wb_dat_r;
	arcade_av_pkg::core_video_t     core_video;
	arcade_av_pkg::board_video_t    board_video;
	logic [7:0]                     audio_sample;
	arcade_ctrl_pkg::game_buttons_t buttons;
	logic                           core_reset, audio_l, audio_r;

	int                             seed = 32'h3265_6cd6;
	int                             cycle_count = 0;
	logic [31:0]                    cur_status;
	logic [7:0]                     cur_joy0, cur_joy1;
	arcade_ctrl_pkg::key_buttons_t  key_model;

	arcade_io_top #(.DAC_BITS(8)) dut_i (
		.clk_28, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
		.wb_ack, .core_video, .audio_sample, .buttons, .core_reset, .board_video,
		.audio_l, .audio_r
	);

	initial clk_28 = 1'b0;
	always #CLK_HALF clk_28 = ~clk_28;

	`include "arcade_io_tb_model.svh"

	// Hang guard
	always @(posedge clk_28) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			$display("Test hung, no end after %0d clock cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "Cycle limit exceeded");
		end
	end

	// --------------------
	// Helpers
	function automatic logic [31:0] next_random();
		next_random = $random(seed);
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_28);
			#DRIVE_DELAY;
		end
	endtask

	task automatic write_status(input logic [31:0] s);
		wb_write(arcade_ctrl_pkg::ADDR_STATUS, s);
		cur_status = s;
	endtask

	task automatic write_joy(input logic [31:0] data);
		wb_write(arcade_ctrl_pkg::ADDR_JOY, data);
		cur_joy0 = data[7:0];
		cur_joy1 = data[15:8];
	endtask

	task automatic check_controls();
		compare_value("buttons", 32'(buttons),
			32'(map_buttons(key_model, cur_joy0, cur_joy1, cur_status[2])));
		compare_value("core_reset", 32'(core_reset), 32'(cur_status[0] | cur_status[6]));
	endtask

	// --------------------
	// Test sequence
	initial begin
		logic [31:0] rnd, data, rd, ones;
		logic [7:0]  code;
		int          idx;

		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = '0;
		core_video = '0;
		audio_sample = 8'h00;
		cur_status = '0;
		cur_joy0 = 8'h00;
		cur_joy1 = 8'h00;
		key_model = '0;

		wait_cycles(1);
		compare_value("core_reset", 32'(core_reset), 32'h1); // Held during reset
		compare_value("buttons", 32'(buttons), 32'hFF);
		compare_value("board_video", 32'(board_video), 32'h0);
		compare_value("audio_l", 32'(audio_l), 32'h0);
		compare_value("audio_r", 32'(audio_r), 32'h0);
		compare_value("wb_ack", 32'(wb_ack), 32'h0);
		wait_cycles(3);
		reset = 1'b0;

		// Register write and read back
		repeat (20) begin
			rnd = next_random();
			data = next_random();
			if (rnd[0]) begin
				write_joy(data);
				wb_read(arcade_ctrl_pkg::ADDR_JOY, rd);
				compare_value("wb_dat_r", rd, {16'h0000, data[15:0]});
			end else begin
				write_status(data);
				wb_read(arcade_ctrl_pkg::ADDR_STATUS, rd);
				compare_value("wb_dat_r", rd, data);
			end
		end
		wb_read(arcade_ctrl_pkg::ADDR_KEY, rd);
		compare_value("wb_dat_r", rd, 32'h0);

		// Key events in normal then rotated orientation
		write_status(32'h0000_0004);
		write_joy(32'h0);
		for (int i = 0; i < 200; i++) begin
			if (i == 100)
				write_status(32'h0);
			idx = int'(next_random() % 12);
			rnd = next_random();
			code = (idx < 9) ? KNOWN_CODES[idx] : rnd[7:0];
			wb_write(arcade_ctrl_pkg::ADDR_KEY, {23'h0, rnd[8], code});
			key_model = latch_key(key_model, rnd[8], code);
			wait_cycles(3);
			check_controls();
		end

		// Joysticks, rotation and core reset bits
		for (int i = 0; i < 100; i++) begin
			write_joy(next_random());
			data = next_random();
			if (i % 4 == 0)
				data = data & ~32'h0000_0041; // Both reset bits clear
			write_status(data);
			wait_cycles(2);
			check_controls();
		end
		write_status(32'h0000_0001);
		wait_cycles(2);
		check_controls();
		write_status(32'h0000_0040);
		wait_cycles(2);
		check_controls();
		write_status(32'h0);
		wait_cycles(2);
		check_controls();

		// Video gate
		repeat (300) begin
			rnd = next_random();
			core_video = arcade_av_pkg::core_video_t'(rnd[10:0]);
			wait_cycles(1);
			compare_value("board_video", 32'(board_video), 32'(gate_video(core_video)));
		end

		// Audio bitstream density
		repeat (6) begin
			rnd = next_random();
			audio_sample = rnd[7:0];
			wait_cycles(2);
			ones = '0;
			repeat (256) begin
				wait_cycles(1);
				if (audio_l)
					ones = ones + 1;
				compare_value("audio_r", 32'(audio_r), 32'(audio_l));
			end
			compare_value("audio_l ones", ones, {24'h0, audio_sample});
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
hdl/arcade_ctrl_pkg.sv
hdl/arcade_av_pkg.sv
hdl/host_status_regs.sv
hdl/ps2_key_latch.sv
hdl/control_mapper.sv
hdl/video_blank_gate.sv
hdl/sigma_delta_dac.sv
hdl/arcade_io_top.sv
verification/arcade_io_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := arcade_io_tb
FILELIST  := list.f
BUILD     := obj_dir

SIM     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/arcade_io_tb_model.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD)
